//--- rtl/uCore_defs.svh
/*
 * Sizing macros for the micro core.
 * Word and address widths, memory depth per region,
 * register index width, instruction field widths and
 * the region select values of the top address bit.
 */
`ifndef UCORE_DEFS_SVH
`define UCORE_DEFS_SVH

// Data and instruction word width.
`define UC_WORD 16

// Low address bits; the full bus address adds the region bit.
`define UC_ALOW 15
`define UC_ABUS (`UC_ALOW + 1)

// Words implemented per region (log2).
`define UC_MEMDEPTH_LOG 9

// Register index width (eight registers).
`define UC_NREG_LOG 3

// Instruction field widths.
`define UC_OPC_W 4
`define UC_IMM_W 9

// Region select carried on the top bus address bit.
`define UC_REGION_INSTR 1'b0
`define UC_REGION_DATA 1'b1

`endif

//--- rtl/uCorePkg.sv
/*
 * Shared types of the micro core.
 * Opcode enum, the two instruction formats and their union,
 * core to coordinator request and status, the memory bus,
 * the program-load write and the retire and write traces.
 */
`include "uCore_defs.svh"

package uCorePkg;

	// ---------------------------------------------------------
	// Instruction set.
	// ---------------------------------------------------------

	// Nine operations; the remaining codes are unused.
	typedef enum logic [`UC_OPC_W-1:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_XOR  = 4'h3,
		OP_ADDI = 4'h4,
		OP_LD   = 4'h5,
		OP_ST   = 4'h6,
		OP_SWP  = 4'h7,
		OP_HALT = 4'h8
	} opcodeE;

	// Register format; rd <= rs op rt, memory address from rs.
	typedef struct packed {
		opcodeE                                    opcode;
		logic [`UC_NREG_LOG-1:0]                   rd;
		logic [`UC_NREG_LOG-1:0]                   rs;
		logic [`UC_NREG_LOG-1:0]                   rt;
		logic [`UC_WORD-`UC_OPC_W-3*`UC_NREG_LOG-1:0] pad;
	} rFmtT;

	// Immediate format; rd <= rd + sext(imm).
	typedef struct packed {
		opcodeE                  opcode;
		logic [`UC_NREG_LOG-1:0] rd;
		logic [`UC_IMM_W-1:0]    imm;
	} iFmtT;

	// One fetched word, read either way.
	typedef union packed {
		rFmtT r;
		iFmtT i;
	} instrU;

	// ---------------------------------------------------------
	// Core, coordinator and memory connections.
	// ---------------------------------------------------------

	// Data request; en is a one-cycle strobe from the fetch cycle.
	typedef struct packed {
		logic                en;
		logic                wr;
		logic                swp;
		logic [`UC_ALOW-1:0] addr;
		logic [`UC_WORD-1:0] data;
	} dReqT;

	// Coordinator status, decoded straight from its state.
	typedef struct packed {
		logic dRead;
		logic dEnd;
	} dStatT;

	// Memory bus; top address bit is the region.
	typedef struct packed {
		logic [`UC_ABUS-1:0] addr;
		logic [`UC_WORD-1:0] data;
		logic                wr;
	} memBusT;

	// Program-load write strobe.
	typedef struct packed {
		logic                en;
		logic [`UC_ABUS-1:0] addr;
		logic [`UC_WORD-1:0] data;
	} loadT;

	// ---------------------------------------------------------
	// Trace outputs.
	// ---------------------------------------------------------

	typedef struct packed {
		logic                    valid;
		logic [`UC_ALOW-1:0]     pc;
		logic [`UC_NREG_LOG-1:0] rd;
		logic [`UC_WORD-1:0]     value;
		logic                    wrReg;
	} retireT;

	// Data write, region bit removed.
	typedef struct packed {
		logic                valid;
		logic [`UC_ALOW-1:0] addr;
		logic [`UC_WORD-1:0] data;
	} memWrT;

endpackage

//--- rtl/CoreMem.sv
/*
 * Memory coordinator between instruction fetch and data access.
 * Two-bit FSM: idle fetch, write, read and swap-read.
 * Swap-read is always followed by write.
 */
`include "uCore_defs.svh"

module CoreMem (
	input  logic                i_clk,
	input  logic                i_rstN,
	input  logic [`UC_ALOW-1:0] i_iAddr,
	input  uCorePkg::dReqT      i_dReq,
	output uCorePkg::dStatT     o_dStat,
	output uCorePkg::memBusT    o_bus
);

	// State encodings.
	localparam logic [1:0] ST_IDLE  = 2'b00;
	localparam logic [1:0] ST_WRITE = 2'b01;

	logic [1:0]          stateQ;
	logic [1:0]          stateD;
	logic [1:0]          stateNew;
	logic [1:0]          stateNext;
	logic                startOp;
	logic                inIdle;
	logic                inWrite;
	logic [`UC_ALOW-1:0] saveAddrQ;
	logic [`UC_WORD-1:0] saveDataQ;
	logic [`UC_ALOW-1:0] lowAddr;

	// ---------------------------------------------------------
	// State machine.
	// ---------------------------------------------------------

	assign inIdle  = (stateQ == ST_IDLE);
	assign inWrite = (stateQ == ST_WRITE);

	// New ops only start from idle.
	assign startOp = i_dReq.en & inIdle;

	// LD gives 10, ST gives 01, SWP gives 11.
	assign stateNew = {i_dReq.swp | ~i_dReq.wr, i_dReq.swp | i_dReq.wr};

	// Swap-read moves to write; everything else back to idle.
	assign stateNext = {1'b0, &stateQ};

	assign stateD = startOp ? stateNew : stateNext;

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			stateQ <= ST_IDLE;
		end else begin
			stateQ <= stateD;
		end
	end

	// Address and data sampled every cycle.
	// The core holds them during the access, so a swap keeps the old value.
	always_ff @(posedge i_clk) begin
		saveAddrQ <= i_dReq.addr;
		saveDataQ <= i_dReq.data;
	end

	// ---------------------------------------------------------
	// Status and bus.
	// ---------------------------------------------------------

	// Read in 10 and 11; end in 10 and 01.
	assign o_dStat.dRead = stateQ[1];
	assign o_dStat.dEnd  = stateQ[1] ^ stateQ[0];

	// Idle fetches the instruction; other states use the saved address.
	assign lowAddr = inIdle ? i_iAddr : saveAddrQ;

	assign o_bus.addr = {inIdle ? `UC_REGION_INSTR : `UC_REGION_DATA, lowAddr};
	assign o_bus.data = saveDataQ;
	assign o_bus.wr   = inWrite;

endmodule

//--- rtl/CoreCtrl.sv
/*
 * Core control: program counter, decode, ALU and halt flag.
 * Issues data requests to the coordinator and completes
 * loads, stores and swaps from its status.
 */
`include "uCore_defs.svh"

module CoreCtrl (
	input  logic                    i_clk,
	input  logic                    i_rstN,
	input  logic                    i_run,
	input  uCorePkg::instrU         i_instr,
	input  logic [`UC_WORD-1:0]     i_rdData,
	input  uCorePkg::dStatT         i_dStat,
	output logic [`UC_ALOW-1:0]     o_iAddr,
	output uCorePkg::dReqT          o_dReq,
	output logic [`UC_NREG_LOG-1:0] o_rsIdx,
	output logic [`UC_NREG_LOG-1:0] o_rtIdx,
	input  logic [`UC_WORD-1:0]     i_rsVal,
	input  logic [`UC_WORD-1:0]     i_rtVal,
	output logic                    o_wrEn,
	output logic [`UC_NREG_LOG-1:0] o_wrIdx,
	output logic [`UC_WORD-1:0]     o_wrVal,
	output uCorePkg::retireT        o_retire,
	output logic                    o_halted
);

	uCorePkg::opcodeE        op;
	logic [`UC_NREG_LOG-1:0] rd;
	logic [`UC_WORD-1:0]     immExt;
	logic [`UC_WORD-1:0]     aluVal;
	logic                    idle;
	logic                    inWrite;
	logic                    fetchEn;
	logic                    reqEn;
	logic                    isAlu;
	logic                    isLd;
	logic                    isSt;
	logic                    isSwp;
	logic                    isMem;
	logic                    isHalt;
	logic [`UC_ALOW-1:0]     pcQ;
	logic                    haltedQ;
	// Pending access, captured at request time.
	logic [`UC_ALOW-1:0]     pendAddrQ;
	logic [`UC_WORD-1:0]     pendDataQ;
	logic [`UC_NREG_LOG-1:0] pendRdQ;
	logic [`UC_ALOW-1:0]     pendPcQ;
	logic                    pendSwpQ;
	// Old memory word of a swap, kept for its retire.
	logic [`UC_WORD-1:0]     readValQ;

	// ---------------------------------------------------------
	// Decode.
	// ---------------------------------------------------------

	assign op     = i_instr.r.opcode;
	assign rd     = i_instr.r.rd;
	assign immExt = {{(`UC_WORD-`UC_IMM_W){i_instr.i.imm[`UC_IMM_W-1]}}, i_instr.i.imm};

	assign isAlu  = (op == uCorePkg::OP_ADD) | (op == uCorePkg::OP_SUB) |
	                (op == uCorePkg::OP_AND) | (op == uCorePkg::OP_XOR) |
	                (op == uCorePkg::OP_ADDI);
	assign isLd   = (op == uCorePkg::OP_LD);
	assign isSt   = (op == uCorePkg::OP_ST);
	assign isSwp  = (op == uCorePkg::OP_SWP);
	assign isMem  = isLd | isSt | isSwp;
	assign isHalt = (op == uCorePkg::OP_HALT);

	// Coordinator idle is the only cycle with a valid instruction.
	assign idle    = ~i_dStat.dRead & ~i_dStat.dEnd;
	assign inWrite = ~i_dStat.dRead & i_dStat.dEnd;
	assign fetchEn = i_run & ~haltedQ & idle;
	assign reqEn   = fetchEn & isMem;

	// ADDI reads rd as its source; SWP reads rd as store data.
	assign o_rsIdx = (op == uCorePkg::OP_ADDI) ? rd : i_instr.r.rs;
	assign o_rtIdx = isSwp ? rd : i_instr.r.rt;

	always_comb begin
		case (op)
			uCorePkg::OP_ADD:  aluVal = i_rsVal + i_rtVal;
			uCorePkg::OP_SUB:  aluVal = i_rsVal - i_rtVal;
			uCorePkg::OP_AND:  aluVal = i_rsVal & i_rtVal;
			uCorePkg::OP_XOR:  aluVal = i_rsVal ^ i_rtVal;
			uCorePkg::OP_ADDI: aluVal = i_rsVal + immExt;
			default:           aluVal = '0;
		endcase
	end

	// ---------------------------------------------------------
	// Requests and register write.
	// ---------------------------------------------------------

	assign o_iAddr = pcQ;

	// Held during the access; the coordinator resamples them each cycle.
	assign o_dReq.en   = reqEn;
	assign o_dReq.wr   = isSt;
	assign o_dReq.swp  = isSwp;
	assign o_dReq.addr = idle ? i_rsVal[`UC_ALOW-1:0] : pendAddrQ;
	assign o_dReq.data = idle ? i_rtVal : pendDataQ;

	// Loads and swaps write rd when the read word arrives.
	assign o_wrEn  = (fetchEn & isAlu) | i_dStat.dRead;
	assign o_wrIdx = i_dStat.dRead ? pendRdQ : rd;
	assign o_wrVal = i_dStat.dRead ? i_rdData : aluVal;

	// ---------------------------------------------------------
	// Retire trace.
	// ---------------------------------------------------------

	// HALT does not retire; unused opcodes retire as no-ops.
	always_comb begin
		o_retire = '0;
		if (fetchEn && !isMem && !isHalt) begin
			o_retire = '{valid: 1'b1, pc: pcQ, rd: rd, value: aluVal, wrReg: isAlu};
		end else if (i_dStat.dRead && i_dStat.dEnd) begin
			o_retire = '{valid: 1'b1, pc: pendPcQ, rd: pendRdQ, value: i_rdData, wrReg: 1'b1};
		end else if (inWrite) begin
			o_retire.valid = 1'b1;
			o_retire.pc    = pendPcQ;
			o_retire.rd    = pendRdQ;
			o_retire.value = pendSwpQ ? readValQ : pendDataQ;
			o_retire.wrReg = pendSwpQ;
		end
	end

	// ---------------------------------------------------------
	// State.
	// ---------------------------------------------------------

	// PC parks at zero while stopped; halted is sticky until reset.
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			pcQ     <= '0;
			haltedQ <= 1'b0;
		end else if (!i_run) begin
			pcQ <= '0;
		end else if (fetchEn) begin
			if (isHalt) begin
				haltedQ <= 1'b1;
			end else begin
				pcQ <= pcQ + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (reqEn) begin
			pendAddrQ <= i_rsVal[`UC_ALOW-1:0];
			pendDataQ <= i_rtVal;
			pendRdQ   <= rd;
			pendPcQ   <= pcQ;
			pendSwpQ  <= isSwp;
		end
		if (i_dStat.dRead) begin
			readValQ <= i_rdData;
		end
	end

	assign o_halted = haltedQ;

endmodule

//--- rtl/RegFile.sv
/*
 * Eight by sixteen register file.
 * Two asynchronous read ports, one synchronous write port.
 * r0 reads zero and ignores writes.
 */
`include "uCore_defs.svh"

module RegFile (
	input  logic                    i_clk,
	input  logic                    i_rstN,
	input  logic [`UC_NREG_LOG-1:0] i_rsIdx,
	input  logic [`UC_NREG_LOG-1:0] i_rtIdx,
	output logic [`UC_WORD-1:0]     o_rsVal,
	output logic [`UC_WORD-1:0]     o_rtVal,
	input  logic                    i_wrEn,
	input  logic [`UC_NREG_LOG-1:0] i_wrIdx,
	input  logic [`UC_WORD-1:0]     i_wrVal
);

	localparam int NREG = 1 << `UC_NREG_LOG;

	// Only r1 upward have storage.
	logic [`UC_WORD-1:0] regs [1:NREG-1];

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			for (int i = 1; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wrEn && (i_wrIdx != '0)) begin
			regs[i_wrIdx] <= i_wrVal;
		end
	end

	// Read ports.
	assign o_rsVal = (i_rsIdx == '0) ? '0 : regs[i_rsIdx];
	assign o_rtVal = (i_rtIdx == '0) ? '0 : regs[i_rtIdx];

endmodule

//--- rtl/MainMem.sv
/*
 * Unified word memory split into instruction and data regions.
 * Asynchronous read, synchronous write from the bus or the load port.
 * Addresses wrap inside each region.
 */
`include "uCore_defs.svh"

module MainMem (
	input  logic                i_clk,
	input  uCorePkg::memBusT    i_bus,
	input  uCorePkg::loadT      i_load,
	output logic [`UC_WORD-1:0] o_rdData
);

	localparam int DEPTH = 1 << `UC_MEMDEPTH_LOG;

	logic [`UC_WORD-1:0]         instrMem [DEPTH];
	logic [`UC_WORD-1:0]         dataMem  [DEPTH];
	logic [`UC_MEMDEPTH_LOG-1:0] busIdx;
	logic [`UC_MEMDEPTH_LOG-1:0] loadIdx;
	logic                        busData;
	logic                        loadData;

	// ---------------------------------------------------------
	// Region and index decode.
	// ---------------------------------------------------------

	assign busIdx   = i_bus.addr[`UC_MEMDEPTH_LOG-1:0];
	assign loadIdx  = i_load.addr[`UC_MEMDEPTH_LOG-1:0];
	assign busData  = (i_bus.addr[`UC_ALOW] == `UC_REGION_DATA);
	assign loadData = (i_load.addr[`UC_ALOW] == `UC_REGION_DATA);

	// ---------------------------------------------------------
	// Write.
	// ---------------------------------------------------------

	// Bus and load writes never coincide.
	always_ff @(posedge i_clk) begin
		if (i_bus.wr) begin
			if (busData) begin
				dataMem[busIdx] <= i_bus.data;
			end else begin
				instrMem[busIdx] <= i_bus.data;
			end
		end else if (i_load.en) begin
			if (loadData) begin
				dataMem[loadIdx] <= i_load.data;
			end else begin
				instrMem[loadIdx] <= i_load.data;
			end
		end
	end

	// Read word, instruction or load data.
	assign o_rdData = busData ? dataMem[busIdx] : instrMem[busIdx];

endmodule

//--- rtl/MicroTop.sv
/*
 * Top level of the micro core.
 * Joins core control, the memory coordinator, the register file
 * and the unified memory; gates the load port and exports the
 * data write trace.
 */
`include "uCore_defs.svh"

module MicroTop (
	input  logic               i_clk,
	input  logic               i_rstN,
	input  logic               i_run,
	input  uCorePkg::loadT     i_load,
	output uCorePkg::retireT   o_retire,
	output uCorePkg::memWrT    o_memWr,
	output logic               o_halted
);

	logic [`UC_ALOW-1:0]     iAddr;
	uCorePkg::dReqT          dReq;
	uCorePkg::dStatT         dStat;
	uCorePkg::memBusT        bus;
	logic [`UC_WORD-1:0]     rdData;
	logic [`UC_NREG_LOG-1:0] rsIdx;
	logic [`UC_NREG_LOG-1:0] rtIdx;
	logic [`UC_WORD-1:0]     rsVal;
	logic [`UC_WORD-1:0]     rtVal;
	logic                    wrEn;
	logic [`UC_NREG_LOG-1:0] wrIdx;
	logic [`UC_WORD-1:0]     wrVal;
	uCorePkg::loadT          gatedLoad;

	// ---------------------------------------------------------
	// Load port and trace.
	// ---------------------------------------------------------

	// Loading only while stopped.
	always_comb begin
		gatedLoad    = i_load;
		gatedLoad.en = i_load.en & ~i_run;
	end

	// Data writes without the region bit.
	assign o_memWr.valid = bus.wr;
	assign o_memWr.addr  = bus.addr[`UC_ALOW-1:0];
	assign o_memWr.data  = bus.data;

	// ---------------------------------------------------------
	// Instances.
	// ---------------------------------------------------------

	CoreCtrl i_CoreCtrl (
		.i_clk    (i_clk),
		.i_rstN   (i_rstN),
		.i_run    (i_run),
		.i_instr  (rdData),
		.i_rdData (rdData),
		.i_dStat  (dStat),
		.o_iAddr  (iAddr),
		.o_dReq   (dReq),
		.o_rsIdx  (rsIdx),
		.o_rtIdx  (rtIdx),
		.i_rsVal  (rsVal),
		.i_rtVal  (rtVal),
		.o_wrEn   (wrEn),
		.o_wrIdx  (wrIdx),
		.o_wrVal  (wrVal),
		.o_retire (o_retire),
		.o_halted (o_halted)
	);

	CoreMem i_CoreMem (
		.i_clk   (i_clk),
		.i_rstN  (i_rstN),
		.i_iAddr (iAddr),
		.i_dReq  (dReq),
		.o_dStat (dStat),
		.o_bus   (bus)
	);

	RegFile i_RegFile (
		.i_clk   (i_clk),
		.i_rstN  (i_rstN),
		.i_rsIdx (rsIdx),
		.i_rtIdx (rtIdx),
		.o_rsVal (rsVal),
		.o_rtVal (rtVal),
		.i_wrEn  (wrEn),
		.i_wrIdx (wrIdx),
		.i_wrVal (wrVal)
	);

	MainMem i_MainMem (
		.i_clk    (i_clk),
		.i_bus    (bus),
		.i_load   (gatedLoad),
		.o_rdData (rdData)
	);

endmodule

//--- bench/MicroTop_chk.sv
/*
 * Concurrent assertions on the memory coordinator.
 * Swap-read is followed by write, write and read last one
 * cycle, and the bus writes only in the write state and
 * only into the data region.
 */
`include "uCore_defs.svh"

module MicroTop_chk (
	input logic       i_clk,
	input logic       i_rstN,
	input logic [1:0] i_state,
	input logic       i_busWr,
	input logic       i_busRegion
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [1:0] ST_IDLE  = 2'b00;
	localparam logic [1:0] ST_WRITE = 2'b01;
	localparam logic [1:0] ST_READ  = 2'b10;
	localparam logic [1:0] ST_SWAP  = 2'b11;

	// Failure count, read by the testbench at the end.
	int nFail = 0;

	// Swap-read always hands over to write.
	aSwapThenWrite: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_state == ST_SWAP |=> i_state == ST_WRITE)
		else begin
			nFail++;
			$error("Swap-read state was not followed by the write state");
		end

	// Write and read each take a single cycle.
	aWriteOne: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_state == ST_WRITE |=> i_state == ST_IDLE)
		else begin
			nFail++;
			$error("Write state lasted longer than one cycle");
		end

	aReadOne: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_state == ST_READ |=> i_state == ST_IDLE)
		else begin
			nFail++;
			$error("Read state lasted longer than one cycle");
		end

	// Bus write belongs to the write state and never reaches the program.
	aWriteExcl: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_busWr |-> (i_state == ST_WRITE) && (i_busRegion == `UC_REGION_DATA))
		else begin
			nFail++;
			$error("Bus write flag was high outside the write state or the data region");
		end

endmodule

//--- bench/MicroTop_tb.sv
/*
 * Testbench for the micro core top level.
 * Random program generator with an instruction-set model,
 * load and run phases per test, retire and data-write compare
 * tasks, a cycle watchdog and the closing summary.
 */
`include "uCore_defs.svh"

module MicroTop_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NTESTS = 6;
	localparam int MINN   = 16;
	localparam int MAXN   = 64;
	localparam int TAIL   = 4;
	localparam int SETTLE = 8;
	localparam int DEPTH  = 1 << `UC_MEMDEPTH_LOG;
	localparam int NREG   = 1 << `UC_NREG_LOG;
	// Reset, full load, four cycles per instruction, settle window.
	localparam int TEST_CYCLES = 6 + DEPTH + MAXN + TAIL + 2 + 4 * MAXN + SETTLE;
	localparam int LIMIT = NTESTS * TEST_CYCLES + 200;

	logic             i_clk;
	logic             i_rstN;
	logic             i_run;
	uCorePkg::loadT   i_load;
	uCorePkg::retireT o_retire;
	uCorePkg::memWrT  o_memWr;
	logic             o_halted;

	// Model state and expected traces.
	logic [`UC_WORD-1:0] mReg [NREG];
	logic [`UC_WORD-1:0] mData [DEPTH];
	logic [`UC_WORD-1:0] initData [DEPTH];
	uCorePkg::instrU     prog [MAXN + TAIL];
	uCorePkg::retireT    expRet [$];
	uCorePkg::memWrT     expWr [$];

	int   errCount = 0;
	int   checks = 0;
	int   nRetired;
	int   nMemWr;
	int   cycleCnt;
	logic running;

	MicroTop i_MicroTop (
		.i_clk    (i_clk),
		.i_rstN   (i_rstN),
		.i_run    (i_run),
		.i_load   (i_load),
		.o_retire (o_retire),
		.o_memWr  (o_memWr),
		.o_halted (o_halted)
	);

	bind CoreMem MicroTop_chk i_MicroTop_chk (
		.i_clk       (i_clk),
		.i_rstN      (i_rstN),
		.i_state     (stateQ),
		.i_busWr     (o_bus.wr),
		.i_busRegion (o_bus.addr[`UC_ALOW])
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	// Watchdog.
	initial begin
		cycleCnt = 0;
		while (cycleCnt < LIMIT) begin
			@(posedge i_clk);
			cycleCnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", LIMIT);
		$display("ERRORS FOUND");
		$finish;
	end

	// ---------------------------------------------------------
	// Compare tasks and output monitor.
	// ---------------------------------------------------------

	function automatic string retireText(input uCorePkg::retireT r);
		return $sformatf("pc %0d rd %0d value %h wrReg %0b", r.pc, r.rd, r.value, r.wrReg);
	endfunction

	task automatic checkRetire(input uCorePkg::retireT got, input uCorePkg::retireT exp);
		checks++;
		if (got !== exp) begin
			errCount++;
			$display("[ERROR] %0t: retire %s, expected %s", $time,
				retireText(got), retireText(exp));
		end
	endtask

	task automatic checkMemWr(input uCorePkg::memWrT got, input uCorePkg::memWrT exp);
		checks++;
		if (got !== exp) begin
			errCount++;
			$display("[ERROR] %0t: data write addr %h data %h, expected addr %h data %h",
				$time, got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	// Outputs are sampled at the rising edge, inputs move on the falling one.
	always @(posedge i_clk) begin
		if (i_rstN && o_retire.valid) begin
			if (!running) begin
				errCount++;
				$display("An instruction retired while the core was stopped, at %0t", $time);
			end else if (expRet.size() == 0) begin
				errCount++;
				$display("An extra instruction retired at pc %0d, at %0t", o_retire.pc, $time);
			end else begin
				checkRetire(o_retire, expRet.pop_front());
				nRetired++;
			end
		end
		if (i_rstN && o_memWr.valid) begin
			if (!running || expWr.size() == 0) begin
				errCount++;
				$display("An unexpected data write to %h appeared at %0t", o_memWr.addr, $time);
			end else begin
				checkMemWr(o_memWr, expWr.pop_front());
				nMemWr++;
			end
		end
	end

	// ---------------------------------------------------------
	// Program generator and instruction-set model.
	// ---------------------------------------------------------

	function automatic uCorePkg::instrU genInstr();
		uCorePkg::instrU w;
		int              sel;
		w   = 16'($urandom);
		sel = int'($urandom % 16);
		case (sel)
			0, 1:    w.r.opcode = uCorePkg::OP_ADD;
			2, 3:    w.r.opcode = uCorePkg::OP_SUB;
			4, 5:    w.r.opcode = uCorePkg::OP_AND;
			6, 7:    w.r.opcode = uCorePkg::OP_XOR;
			8, 9:    w.r.opcode = uCorePkg::OP_ADDI;
			10, 11:  w.r.opcode = uCorePkg::OP_LD;
			12, 13:  w.r.opcode = uCorePkg::OP_ST;
			default: w.r.opcode = uCorePkg::OP_SWP;
		endcase
		// Base r0 gives address zero, so stores and loads meet often.
		if (sel >= 10 && ($urandom % 3) == 0) begin
			w.r.rs = '0;
		end
		return w;
	endfunction

	task automatic modelStep(input uCorePkg::instrU w, input int pc);
		uCorePkg::retireT            er;
		logic [`UC_NREG_LOG-1:0]     rd;
		logic [`UC_WORD-1:0]         a;
		logic [`UC_WORD-1:0]         b;
		logic [`UC_WORD-1:0]         v;
		logic [`UC_ALOW-1:0]         addr;
		logic [`UC_MEMDEPTH_LOG-1:0] idx;
		rd   = w.r.rd;
		a    = mReg[w.r.rs];
		b    = mReg[w.r.rt];
		addr = a[`UC_ALOW-1:0];
		idx  = addr[`UC_MEMDEPTH_LOG-1:0];
		er   = '0;
		er.valid = 1'b1;
		er.pc    = pc[`UC_ALOW-1:0];
		er.rd    = rd;
		er.wrReg = 1'b1;
		case (w.r.opcode)
			uCorePkg::OP_ADD:  v = a + b;
			uCorePkg::OP_SUB:  v = a - b;
			uCorePkg::OP_AND:  v = a & b;
			uCorePkg::OP_XOR:  v = a ^ b;
			uCorePkg::OP_ADDI: v = mReg[rd] + {{(`UC_WORD-`UC_IMM_W){w.i.imm[`UC_IMM_W-1]}},
				w.i.imm};
			uCorePkg::OP_LD:   v = mData[idx];
			uCorePkg::OP_ST: begin
				// Store retires with its data and writes no register.
				v        = b;
				er.wrReg = 1'b0;
				expWr.push_back('{valid: 1'b1, addr: addr, data: b});
				mData[idx] = b;
			end
			uCorePkg::OP_SWP: begin
				v = mData[idx];
				expWr.push_back('{valid: 1'b1, addr: addr, data: mReg[rd]});
				mData[idx] = mReg[rd];
			end
			default: v = '0;
		endcase
		er.value = v;
		expRet.push_back(er);
		if (er.wrReg && rd != '0) begin
			mReg[rd] = v;
		end
	endtask

	// ---------------------------------------------------------
	// Stimulus.
	// ---------------------------------------------------------

	task automatic applyReset();
		@(negedge i_clk);
		i_rstN  = 1'b0;
		i_run   = 1'b0;
		running = 1'b0;
		i_load  = '0;
		repeat (5) @(negedge i_clk);
		i_rstN = 1'b1;
		@(posedge i_clk);
		if (o_retire.valid || o_memWr.valid || o_halted) begin
			errCount++;
			$display("Outputs were active right after reset, at %0t", $time);
		end
	endtask

	task automatic loadWord(input logic region, input int idx, input logic [`UC_WORD-1:0] data);
		logic [`UC_ALOW-1:0] low;
		low = idx[`UC_ALOW-1:0];
		@(negedge i_clk);
		i_load.en   = 1'b1;
		i_load.addr = {region, low};
		i_load.data = data;
	endtask

	task automatic runTest(input int t);
		int              n;
		int              errBefore;
		uCorePkg::instrU halt;
		n         = MINN + int'($urandom % (MAXN - MINN + 1));
		errBefore = errCount;
		nRetired  = 0;
		nMemWr    = 0;
		expRet.delete();
		expWr.delete();
		foreach (mReg[r]) begin
			mReg[r] = '0;
		end
		foreach (initData[a]) begin
			initData[a] = 16'($urandom);
			mData[a]    = initData[a];
		end
		// The model runs as the program is built.
		for (int pc = 0; pc < n - 1; pc++) begin
			prog[pc] = genInstr();
			modelStep(prog[pc], pc);
		end
		halt          = 16'($urandom);
		halt.r.opcode = uCorePkg::OP_HALT;
		prog[n - 1]   = halt;
		// Random words past HALT must never execute.
		for (int k = n; k < n + TAIL; k++) begin
			prog[k] = 16'($urandom);
		end
		applyReset();
		foreach (initData[a]) begin
			loadWord(`UC_REGION_DATA, a, initData[a]);
		end
		for (int k = 0; k < n + TAIL; k++) begin
			loadWord(`UC_REGION_INSTR, k, prog[k]);
		end
		@(negedge i_clk);
		i_load = '0;
		@(negedge i_clk);
		i_run   = 1'b1;
		running = 1'b1;
		while (!o_halted) begin
			@(posedge i_clk);
		end
		repeat (SETTLE) @(posedge i_clk);
		if (!o_halted) begin
			errCount++;
			$display("Test %0d: the halted flag dropped again before reset", t);
		end
		if (expRet.size() != 0 || expWr.size() != 0) begin
			errCount++;
			$display("Test %0d halted with %0d retires and %0d data writes missing",
				t, expRet.size(), expWr.size());
		end
		$display("Test %0d: %0d instructions, %0d retired, %0d data writes, %0d errors",
			t, n, nRetired, nMemWr, errCount - errBefore);
	endtask

	initial begin
		int assertFails;
		$timeformat(-9, 0, " ns", 0);
		void'($urandom(92423));
		i_rstN  = 1'b0;
		i_run   = 1'b0;
		i_load  = '0;
		running = 1'b0;
		for (int t = 0; t < NTESTS; t++) begin
			runTest(t);
		end
		assertFails = i_MicroTop.i_CoreMem.i_MicroTop_chk.nFail;
		$display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			NTESTS, checks, errCount, assertFails);
		if (errCount == 0 && assertFails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+rtl
rtl/uCorePkg.sv
rtl/CoreMem.sv
rtl/CoreCtrl.sv
rtl/RegFile.sv
rtl/MainMem.sv
rtl/MicroTop.sv
bench/MicroTop_chk.sv
bench/MicroTop_tb.sv

//--- Bender.yml
package:
  name: ucore

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uCorePkg.sv
      - rtl/CoreMem.sv
      - rtl/CoreCtrl.sv
      - rtl/RegFile.sv
      - rtl/MainMem.sv
      - rtl/MicroTop.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/MicroTop_chk.sv
      - bench/MicroTop_tb.sv
